// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := axi_mem_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/mem_cfg.svh

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: common/axi_pkg.sv
`default_nettype none
`include "mem_cfg.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY = 2'b00               // only response this slave gives
    } axi_resp_e;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;         // write id, echoed on b
        logic [`AXI_ADDR_W-1:0] addr;       // byte address
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;     // one enable per byte lane
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;         // read id, echoed on r
        logic [`AXI_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        axi_resp_e            resp;
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        axi_resp_e              resp;
    } axi_r_t;

endpackage

`default_nettype wire

// File: common/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// byte address width on the slave port
`define AXI_ADDR_W 32

// data width, one beat per transfer
`define AXI_DATA_W 32

// transaction id width, carried through to b and r
`define AXI_ID_W 4

// word index width, 1024 words of storage
`define MEM_ADDR_BITS 10

// response queue slots, equal to the issuer credits
`define MEM_RSP_DEPTH 4

`endif

// File: common/mem_pkg.sv
`default_nettype none
`include "mem_cfg.svh"

package mem_pkg;

    // request into the ram, one per accepted aw/w pair or ar
    typedef struct packed {
        logic                     we;       // 1 = write, 0 = read
        logic [`MEM_ADDR_BITS-1:0] addr;    // word index, byte offset dropped
        logic [`AXI_DATA_W-1:0]   wdata;
        logic [`AXI_DATA_W/8-1:0] strb;     // all ones on reads
        logic [`AXI_ID_W-1:0]     id;
    } mem_req_t;

    // response out of the ram, pushed into the queue
    typedef struct packed {
        logic                   we;         // selects b or r downstream
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] rdata;      // don't care for writes
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: dv/axi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module axi_mem_tb
    import axi_pkg::*;
;
    localparam int DEPTH      = `MEM_RSP_DEPTH;
    localparam int MAX_CYCLES = 4000;            // well above the ~600 cycles all phases need
    localparam int RDY_HIGH   = 0;
    localparam int RDY_LOW    = 1;
    localparam int RDY_RAND   = 2;

    typedef struct packed {
        logic                   we;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
    } exp_t;

    logic    clk_i;
    logic    rst_ni;
    axi_aw_t aw;
    logic    aw_valid, aw_ready;
    axi_w_t  w;
    logic    w_valid, w_ready;
    axi_ar_t ar;
    logic    ar_valid, ar_ready;
    axi_b_t  b;
    logic    b_valid, b_ready;
    axi_r_t  r;
    logic    r_valid, r_ready;

    logic [31:0]            lfsr = 32'hc5ea;
    int                     ready_mode = RDY_HIGH;
    int                     cycle_cnt = 0;
    logic                   lat_mode = 1'b0;
    logic [`AXI_DATA_W-1:0] shadow [16];       // 16-word test window
    exp_t                   exp_q [$];

    // monitor snapshot, taken mid-cycle so the edge sees settled values
    logic   mon_in_rst = 1'b1;
    logic   mon_wr_pres = 1'b0;
    logic   mon_ar_v = 1'b0;
    logic   mon_acc = 1'b0;
    logic   mon_aw_rdy = 1'b0;
    logic   mon_w_rdy = 1'b0;
    logic   mon_ar_rdy = 1'b0;
    logic   mon_b_v = 1'b0;
    logic   mon_r_v = 1'b0;
    logic   mon_b_fire = 1'b0;
    logic   mon_r_fire = 1'b0;
    logic   mon_lat = 1'b0;
    logic   mon_exp_ok = 1'b0;
    int     mon_infl = 0;
    exp_t   mon_exp = '0;
    axi_b_t mon_b = '0;
    axi_r_t mon_r = '0;

    axi_mem_top dut (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
        .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
        .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready),
        .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "simulation hung");
        end
    end

    task automatic report_fail(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    always @(negedge clk_i) begin
        mon_in_rst  = !rst_ni;
        mon_wr_pres = aw_valid && w_valid;
        mon_ar_v    = ar_valid;
        mon_aw_rdy  = aw_ready;
        mon_w_rdy   = w_ready;
        mon_ar_rdy  = ar_ready;
        mon_b_v     = b_valid;
        mon_r_v     = r_valid;
        mon_b       = b;
        mon_r       = r;
        mon_lat     = lat_mode;
        mon_infl    = exp_q.size();
        mon_exp_ok  = (exp_q.size() != 0);
        mon_exp     = mon_exp_ok ? exp_q[0] : '0;
        mon_b_fire  = rst_ni && b_valid && b_ready;
        mon_r_fire  = rst_ni && r_valid && r_ready;
        mon_acc     = rst_ni && ((mon_wr_pres && aw_ready && w_ready) || (ar_valid && ar_ready));
        if (mon_exp_ok && (mon_b_fire || mon_r_fire)) begin
            void'(exp_q.pop_front());
        end
        if (rst_ni && mon_wr_pres && aw_ready && w_ready) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) shadow[aw.addr[5:2]][i*8 +: 8] = w.data[i*8 +: 8];
            end
            exp_q.push_back(exp_t'{we: 1'b1, id: aw.id, data: '0});
        end else if (rst_ni && ar_valid && ar_ready) begin
            exp_q.push_back(exp_t'{we: 1'b0, id: ar.id, data: shadow[ar.addr[5:2]]});
        end
    end

    a_reset_idle: assert property (@(posedge clk_i) mon_in_rst |-> !mon_b_v && !mon_r_v)
        else report_fail("response valid during reset");
    a_ready_free: assert property (@(posedge clk_i)
        !mon_in_rst && mon_infl < DEPTH && (mon_wr_pres || mon_ar_v)
        |-> (mon_wr_pres ? (mon_aw_rdy && mon_w_rdy) : mon_ar_rdy))
        else report_fail("request not accepted although credits remain");
    a_ready_full: assert property (@(posedge clk_i)
        !mon_in_rst && mon_infl >= DEPTH |-> !mon_aw_rdy && !mon_w_rdy && !mon_ar_rdy)
        else report_fail("request ready with all queue slots in use");
    a_write_first: assert property (@(posedge clk_i) !mon_in_rst && mon_wr_pres |-> !mon_ar_rdy)
        else report_fail("read granted while a write was presented");
    a_b_match: assert property (@(posedge clk_i) mon_b_fire |-> mon_exp_ok && mon_exp.we
        && mon_b.id == mon_exp.id && mon_b.resp == AXI_RESP_OKAY)
        else report_fail("b response does not match expected head");
    a_r_match: assert property (@(posedge clk_i) mon_r_fire |-> mon_exp_ok && !mon_exp.we
        && mon_r.id == mon_exp.id && mon_r.data == mon_exp.data && mon_r.resp == AXI_RESP_OKAY)
        else report_fail("r response does not match expected head");
    a_latency: assert property (@(posedge clk_i)
        mon_lat |-> ((mon_b_v || mon_r_v) == $past(mon_acc, 3)))
        else report_fail("response latency is not 3 cycles");

    task automatic step();
        logic [31:0] v;
        @(posedge clk_i);
        #1;
        draw(2, v);                              // drawn every cycle, keeps the sequence fixed
        b_ready = (ready_mode == RDY_HIGH) || (ready_mode == RDY_RAND && v[1]);
        r_ready = (ready_mode == RDY_HIGH) || (ready_mode == RDY_RAND && v[0]);
    endtask

    task automatic put_write(input logic [3:0] idx, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id);
        aw       = '{id: id, addr: {26'd0, idx, 2'b00}};
        w        = '{data: data, strb: strb};
        aw_valid = 1'b1;
        w_valid  = 1'b1;
    endtask

    task automatic put_read(input logic [3:0] idx, input logic [3:0] id);
        ar       = '{id: id, addr: {26'd0, idx, 2'b00}};
        ar_valid = 1'b1;
    endtask

    task automatic wait_accept();
        logic wr_fire;
        logic rd_fire;
        while (aw_valid || ar_valid) begin
            @(negedge clk_i);
            wr_fire = aw_valid && w_valid && aw_ready && w_ready;
            rd_fire = ar_valid && ar_ready;
            step();
            if (wr_fire) begin
                aw_valid = 1'b0;
                w_valid  = 1'b0;
            end
            if (rd_fire) ar_valid = 1'b0;
        end
    endtask

    task automatic rand_ops(input int n);
        logic [31:0] op;
        logic [31:0] idx;
        logic [31:0] data;
        logic [31:0] strb;
        for (int i = 0; i < n; i++) begin
            draw(2, op);
            draw(4, idx);
            draw(32, data);
            draw(4, strb);
            if (op != 1) put_write(idx[3:0], data, strb[3:0], 4'(i));
            if (op != 0) put_read(4'(idx + 1), 4'(i + 8));     // ids differ from the write
            wait_accept();
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) step();
    endtask

    initial begin
        logic [31:0] v;
        rst_ni = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        // a write held through reset must be taken in the first cycle after
        put_write(4'd0, 32'h0bad_f00d, 4'hf, 4'd0);
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        wait_accept();
        for (int i = 1; i < 16; i++) begin
            draw(32, v);
            put_write(4'(i), v, 4'hf, 4'(i));
            wait_accept();
        end
        for (int i = 0; i < 24; i++) begin
            draw(32, v);
            put_write(v[3:0], {v[31:4], 4'ha}, v[7:4], 4'(i));
            wait_accept();
        end
        for (int i = 0; i < 16; i++) begin
            put_read(4'(i), 4'(15 - i));
            wait_accept();
        end
        ready_mode = RDY_RAND;
        rand_ops(20);
        ready_mode = RDY_HIGH;
        drain();
        repeat (4) step();
        lat_mode = 1'b1;
        for (int i = 0; i < 8; i++) begin
            draw(4, v);
            if (i[0]) put_read(v[3:0], 4'(i));
            else put_write(v[3:0], v, 4'hf, 4'(i));
            wait_accept();
            drain();
            repeat (3) step();
        end
        lat_mode = 1'b0;
        ready_mode = RDY_LOW;
        put_read(4'd3, 4'd7);
        repeat (10) step();                      // only DEPTH of these may be taken
        ar_valid = 1'b0;
        ready_mode = RDY_RAND;
        rand_ops(30);
        ready_mode = RDY_HIGH;
        drain();
        repeat (5) step();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/axi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module axi_mem_top
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_ni,
    input  wire axi_aw_t aw_i,
    input  wire logic    aw_valid_i,
    output logic         aw_ready_o,
    input  wire axi_w_t  w_i,
    input  wire logic    w_valid_i,
    output logic         w_ready_o,
    input  wire axi_ar_t ar_i,
    input  wire logic    ar_valid_i,
    output logic         ar_ready_o,
    output axi_b_t       b_o,
    output logic         b_valid_o,
    input  wire logic    b_ready_i,
    output axi_r_t       r_o,
    output logic         r_valid_o,
    input  wire logic    r_ready_i
);

    mem_req_t mem_req;
    logic     mem_req_valid;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    mem_rsp_t q_head;
    logic     q_not_empty;
    logic     q_pop;
    logic     credit_return;                    // queue pop back to the issuer

    axi_req_issue u_issue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .aw_i            (aw_i),
        .aw_valid_i      (aw_valid_i),
        .aw_ready_o      (aw_ready_o),
        .w_i             (w_i),
        .w_valid_i       (w_valid_i),
        .w_ready_o       (w_ready_o),
        .ar_i            (ar_i),
        .ar_valid_i      (ar_valid_i),
        .ar_ready_o      (ar_ready_o),
        .credit_return_i (credit_return),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid)
    );

    sdp_byte_ram u_ram (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (mem_req),
        .req_valid_i (mem_req_valid),
        .rsp_o       (mem_rsp),
        .rsp_valid_o (mem_rsp_valid)
    );

    rsp_queue u_queue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .push_i          (mem_rsp),
        .push_valid_i    (mem_rsp_valid),
        .head_o          (q_head),
        .not_empty_o     (q_not_empty),
        .pop_i           (q_pop),
        .credit_return_o (credit_return)
    );

    axi_rsp_steer u_steer (
        .head_i      (q_head),
        .not_empty_i (q_not_empty),
        .pop_o       (q_pop),
        .b_o         (b_o),
        .b_valid_o   (b_valid_o),
        .b_ready_i   (b_ready_i),
        .r_o         (r_o),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i)
    );

endmodule

`default_nettype wire

// File: logic/axi_req_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module axi_req_issue
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire axi_aw_t aw_i,
    input  wire logic    aw_valid_i,
    output logic         aw_ready_o,
    input  wire axi_w_t  w_i,
    input  wire logic    w_valid_i,
    output logic         w_ready_o,
    input  wire axi_ar_t ar_i,
    input  wire logic    ar_valid_i,
    output logic         ar_ready_o,
    input  wire logic    credit_return_i,   // one slot freed in the queue
    output mem_req_t     mem_req_o,
    output logic         mem_req_valid_o
);

    localparam int CRED_W = $clog2(`MEM_RSP_DEPTH + 1);
    localparam int OFF_W  = $clog2(`AXI_DATA_W / 8);   // byte offset bits in an address

    logic [CRED_W-1:0] credits_q;
    logic [CRED_W-1:0] credits_d;
    logic              has_credit;
    logic              wr_req;                   // aw and w both presented
    logic              issue;

    assign has_credit = (credits_q != '0);
    assign wr_req     = aw_valid_i & w_valid_i;

    // writes win, ar only sees ready when no write pair is waiting
    assign aw_ready_o = has_credit & wr_req;
    assign w_ready_o  = has_credit & wr_req;
    assign ar_ready_o = has_credit & ~wr_req;

    assign issue           = has_credit & (wr_req | ar_valid_i);
    assign mem_req_valid_o = issue;

    always_comb begin
        mem_req_o.we    = wr_req;
        mem_req_o.wdata = w_i.data;
        if (wr_req) begin
            mem_req_o.addr = aw_i.addr[OFF_W +: `MEM_ADDR_BITS];
            mem_req_o.strb = w_i.strb;
            mem_req_o.id   = aw_i.id;
        end else begin
            mem_req_o.addr = ar_i.addr[OFF_W +: `MEM_ADDR_BITS];
            mem_req_o.strb = '1;                 // full word on reads
            mem_req_o.id   = ar_i.id;
        end
    end

    // spend on issue, regain on return, both cancel out
    always_comb begin
        credits_d = credits_q;
        if (issue && !credit_return_i) begin
            credits_d = credits_q - 1'b1;
        end else if (!issue && credit_return_i) begin
            credits_d = credits_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            credits_q <= CRED_W'(`MEM_RSP_DEPTH);   // queue starts empty
        end else begin
            credits_q <= credits_d;
        end
    end

    // a return without an outstanding credit means the queue popped a phantom entry
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits_q <= CRED_W'(`MEM_RSP_DEPTH))
        else $error("credit counter above queue depth");

    // every return pays back a credit spent earlier, so some must be out
    a_return_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_return_i |-> credits_q != CRED_W'(`MEM_RSP_DEPTH))
        else $error("credit returned while all credits are home");

endmodule

`default_nettype wire

// File: logic/axi_rsp_steer.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module axi_rsp_steer
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire mem_rsp_t head_i,
    input  wire logic     not_empty_i,
    output logic          pop_o,
    output axi_b_t        b_o,
    output logic          b_valid_o,
    input  wire logic     b_ready_i,
    output axi_r_t        r_o,
    output logic          r_valid_o,
    input  wire logic     r_ready_i
);

    // queue head picks its channel from the stored we bit
    assign b_valid_o = not_empty_i & head_i.we;
    assign r_valid_o = not_empty_i & ~head_i.we;

    always_comb begin
        b_o.id   = head_i.id;
        b_o.resp = AXI_RESP_OKAY;
        r_o.id   = head_i.id;
        r_o.data = head_i.rdata;
        r_o.resp = AXI_RESP_OKAY;
    end

    // leaves the queue only on a completed handshake
    assign pop_o = (b_valid_o & b_ready_i) | (r_valid_o & r_ready_i);

endmodule

`default_nettype wire

// File: logic/rsp_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module rsp_queue
    import mem_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire mem_rsp_t push_i,
    input  wire logic     push_valid_i,
    output mem_rsp_t      head_o,
    output logic          not_empty_o,
    input  wire logic     pop_i,
    output logic          credit_return_o
);

    localparam int DEPTH = `MEM_RSP_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_rsp_t          slot_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_pop;
    logic              full;

    assign not_empty_o     = (count_q != '0);
    assign full            = (count_q == CNT_W'(DEPTH));
    assign do_pop          = pop_i & not_empty_o;
    assign credit_return_o = do_pop;             // one credit back per entry leaving
    assign head_o          = slot_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_valid_i) begin
            slot_q[wr_ptr_q] <= push_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_valid_i) - CNT_W'(do_pop);
        end
    end

    // credits upstream must keep the ram pipeline from overrunning us
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_valid_i |-> !full || pop_i)
        else $error("push into full response queue");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> not_empty_o)
        else $error("pop from empty response queue");

endmodule

`default_nettype wire

// File: mem/sdp_byte_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_cfg.svh"

module sdp_byte_ram
    import mem_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire mem_req_t req_i,
    input  wire logic     req_valid_i,
    output mem_rsp_t      rsp_o,
    output logic          rsp_valid_o
);

    localparam int DEPTH = 2 ** `MEM_ADDR_BITS;
    localparam int NB    = `AXI_DATA_W / 8;      // byte lanes

    logic [`AXI_DATA_W-1:0] mem_q [DEPTH];

    mem_rsp_t s1_q;                              // first read register plus tag
    mem_rsp_t s2_q;                              // output register plus tag
    logic     s1_valid_q;
    logic     s2_valid_q;

    // byte lanes written at the acceptance edge
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_i.we) begin
            for (int b = 0; b < NB; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // two stage read path, tag rides alongside the data
    always_ff @(posedge clk_i) begin
        s1_q.rdata <= mem_q[req_i.addr];
        s1_q.we    <= req_i.we;
        s1_q.id    <= req_i.id;
        s2_q       <= s1_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    assign rsp_o       = s2_q;
    assign rsp_valid_o = s2_valid_q;             // push into queue on the next edge

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/axi_pkg.sv
common/mem_pkg.sv
mem/sdp_byte_ram.sv
logic/axi_req_issue.sv
logic/rsp_queue.sv
logic/axi_rsp_steer.sv
logic/axi_mem_top.sv
dv/axi_mem_tb.sv
